/* common/pe_pkg.sv */
package pe_pkg;

    // ========================================
    // PE sizes
    // ========================================

    // rows per PE, one filter each
    localparam int PEROW   = 4;
    // input and weight word width, signed
    localparam int DWD     = 8;
    // psum width, wraps on overflow
    localparam int PSUMDWD = 20;
    // pad depth, max taps per window
    localparam int MAXTAP  = 8;
    // tap index width
    localparam int TAPWD   = 3;

    // ========================================
    // data types
    // ========================================

    typedef logic signed [DWD-1:0]     data_t;
    typedef logic signed [PSUMDWD-1:0] psum_t;

    // one word per row
    typedef data_t [PEROW-1:0] row_data_t;
    typedef psum_t [PEROW-1:0] row_psum_t;

    // ========================================
    // modes and states
    // ========================================

    // psum output mode
    typedef enum logic {
        PS_LOCAL,
        PS_ACC_LPE
    } ps_mode_e;

    // controller FSM
    typedef enum logic [1:0] {
        DPC_IDLE,
        DPC_LOAD_W,
        DPC_LOAD_I,
        DPC_ISSUE
    } dpc_state_e;

    // configuration, held stable while the PE is busy
    typedef struct packed {
        logic [TAPWD-1:0] ntap_m1;
        ps_mode_e         ps_mode;
    } pe_conf_t;

endpackage

/* common/stage_if.sv */
`timescale 1ns/1ps

interface stage_if import pe_pkg::*; ();

    logic             rdy;
    logic             ack;
    // tap tag and end of window
    logic [TAPWD-1:0] tap;
    logic             last;
    ps_mode_e         mode;
    // per-row product or sum
    row_psum_t        prod;

    modport src (
        output rdy, tap, last, mode, prod,
        input  ack
    );

    modport dst (
        input  rdy, tap, last, mode, prod,
        output ack
    );

endinterface

/* hdl/rf_2p.sv */
`timescale 1ns/1ps

module rf_2p import pe_pkg::*; #(
    parameter int LANES = 1,
    parameter int DEPTH = MAXTAP
) (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_write,
    input  logic [$clog2(DEPTH)-1:0]   i_waddr,
    input  logic [LANES*DWD-1:0]       i_wdata,
    input  logic                       i_read,
    input  logic [$clog2(DEPTH)-1:0]   i_raddr,
    output logic [LANES*DWD-1:0]       o_rdata
);

    logic [LANES*DWD-1:0] mem [DEPTH];

    // write port
    always_ff @(posedge i_clk) begin
        if (i_write) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // registered read, holds while idle
    // same-address write shows up one read later
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rdata <= '0;
        end else if (i_read) begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule

/* pe_core/datapath_controller.sv */
`timescale 1ns/1ps

module datapath_controller import pe_pkg::*; (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  pe_conf_t         i_conf,
    input  logic             i_weight_rdy,
    output logic             o_weight_ack,
    input  logic             i_input_rdy,
    output logic             o_input_ack,
    output logic             o_wpad_write,
    output logic [TAPWD-1:0] o_wpad_waddr,
    output logic             o_ipad_write,
    output logic [TAPWD-1:0] o_ipad_waddr,
    stage_if.src             issue
);

    dpc_state_e       state;
    dpc_state_e       state_nxt;
    logic [TAPWD-1:0] tap_cnt;
    logic             cnt_last;
    logic             beat;

    // ========================================
    // handshakes
    // ========================================

    assign cnt_last = (tap_cnt == i_conf.ntap_m1);

    // pad loads, one beat per cycle while rdy
    assign o_weight_ack = (state == DPC_LOAD_W) && i_weight_rdy;
    assign o_input_ack  = (state == DPC_LOAD_I) && i_input_rdy;

    // write data comes straight from the top-level ports
    assign o_wpad_write = o_weight_ack;
    assign o_wpad_waddr = tap_cnt;
    assign o_ipad_write = o_input_ack;
    assign o_ipad_waddr = tap_cnt;

    // one fetch op per tap
    assign issue.rdy  = (state == DPC_ISSUE);
    assign issue.tap  = tap_cnt;
    assign issue.last = cnt_last;
    assign issue.mode = i_conf.ps_mode;
    assign issue.prod = '0;

    // any transfer moves the tap counter
    assign beat = o_weight_ack || o_input_ack || (issue.rdy && issue.ack);

    // ========================================
    // FSM
    // ========================================

    always_comb begin
        state_nxt = state;
        case (state)
            DPC_IDLE: begin
                // weights win over inputs
                if (i_weight_rdy) begin
                    state_nxt = DPC_LOAD_W;
                end else if (i_input_rdy) begin
                    state_nxt = DPC_LOAD_I;
                end
            end
            DPC_LOAD_W: begin
                if (o_weight_ack && cnt_last) begin
                    state_nxt = DPC_IDLE;
                end
            end
            DPC_LOAD_I: begin
                if (o_input_ack && cnt_last) begin
                    state_nxt = DPC_ISSUE;
                end
            end
            DPC_ISSUE: begin
                if (issue.ack && cnt_last) begin
                    state_nxt = DPC_IDLE;
                end
            end
            default: begin
                state_nxt = DPC_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= DPC_IDLE;
            tap_cnt <= '0;
        end else begin
            state <= state_nxt;
            // wraps to 0 at the end of every phase
            if (beat) begin
                tap_cnt <= cnt_last ? '0 : tap_cnt + 1'b1;
            end
        end
    end

endmodule

/* pe_core/mac_pipe.sv */
`timescale 1ns/1ps

module mac_pipe import pe_pkg::*; (
    input  logic             i_clk,
    input  logic             i_rst_n,
    stage_if.dst             issue,
    stage_if.src             ss,
    output logic             o_ipad_read,
    output logic [TAPWD-1:0] o_ipad_raddr,
    input  data_t            i_ipad_rdata,
    output logic             o_wpad_read,
    output logic [TAPWD-1:0] o_wpad_raddr,
    input  row_data_t        i_wpad_rdata
);

    // multiply to sum
    stage_if ms ();

    logic             issue_take;
    logic             fs_valid;
    logic [TAPWD-1:0] fs_tap;
    logic             fs_last;
    ps_mode_e         fs_mode;
    logic             fs_take;
    logic             ms_take;
    row_psum_t        mul_prod;
    row_psum_t        acc;
    row_psum_t        acc_nxt;

    // ========================================
    // fetch stage
    // ========================================

    // free slot, or the slot empties this cycle
    assign issue.ack  = !fs_valid || fs_take;
    assign issue_take = issue.rdy && issue.ack;

    // pad read is the issue transfer itself
    assign o_ipad_read  = issue_take;
    assign o_ipad_raddr = issue.tap;
    assign o_wpad_read  = issue_take;
    assign o_wpad_raddr = issue.tap;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fs_valid <= 1'b0;
        end else if (issue.ack) begin
            fs_valid <= issue.rdy;
        end
    end

    // tags travel alongside the pad data
    always_ff @(posedge i_clk) begin
        if (issue_take) begin
            fs_tap  <= issue.tap;
            fs_last <= issue.last;
            fs_mode <= issue.mode;
        end
    end

    // ========================================
    // multiply stage
    // ========================================

    assign fs_take = fs_valid && (!ms.rdy || ms.ack);

    // input broadcast to every row
    always_comb begin
        for (int r = 0; r < PEROW; r++) begin
            mul_prod[r] = psum_t'(i_ipad_rdata) * psum_t'(i_wpad_rdata[r]);
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ms.rdy <= 1'b0;
        end else if (fs_take) begin
            ms.rdy <= 1'b1;
        end else if (ms.ack) begin
            ms.rdy <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (fs_take) begin
            ms.prod <= mul_prod;
            ms.tap  <= fs_tap;
            ms.last <= fs_last;
            ms.mode <= fs_mode;
        end
    end

    // ========================================
    // sum stage
    // ========================================

    // only a final tap needs the output slot
    assign ms.ack  = !(ms.last && ss.rdy && !ss.ack);
    assign ms_take = ms.rdy && ms.ack;

    // tap 0 starts a new window
    always_comb begin
        for (int r = 0; r < PEROW; r++) begin
            acc_nxt[r] = ((ms.tap == '0) ? psum_t'(0) : acc[r]) + ms.prod[r];
        end
    end

    always_ff @(posedge i_clk) begin
        if (ms_take) begin
            acc <= acc_nxt;
        end
        if (ms_take && ms.last) begin
            ss.prod <= acc_nxt;
            ss.tap  <= ms.tap;
            ss.last <= ms.last;
            ss.mode <= ms.mode;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ss.rdy <= 1'b0;
        end else if (ms_take && ms.last) begin
            ss.rdy <= 1'b1;
        end else if (ss.ack) begin
            ss.rdy <= 1'b0;
        end
    end

endmodule

/* hdl/psum_path.sv */
`timescale 1ns/1ps

module psum_path import pe_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    stage_if.dst      ss,
    input  logic      i_lpe_rdy,
    output logic      o_lpe_ack,
    input  row_psum_t i_psum_lpe,
    output logic      o_pout_rdy,
    input  logic      i_pout_ack,
    output row_psum_t o_psum
);

    logic      acc_lpe;
    logic      out_free;
    logic      src_ok;
    row_psum_t merged;

    // ========================================
    // channel join
    // ========================================

    // mode rides with the sum
    assign acc_lpe  = (ss.mode == PS_ACC_LPE);
    assign out_free = !o_pout_rdy || i_pout_ack;
    // LPE only matters in accumulate mode
    assign src_ok   = !acc_lpe || i_lpe_rdy;

    // ss and LPE taken in the same cycle
    assign ss.ack    = ss.rdy && out_free && src_ok;
    assign o_lpe_ack = ss.ack && acc_lpe;

    always_comb begin
        for (int r = 0; r < PEROW; r++) begin
            if (acc_lpe) begin
                merged[r] = ss.prod[r] + i_psum_lpe[r];
            end else begin
                merged[r] = ss.prod[r];
            end
        end
    end

    // ========================================
    // output register
    // ========================================

    always_ff @(posedge i_clk) begin
        if (ss.ack) begin
            o_psum <= merged;
        end
    end

    // held until the consumer acks
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pout_rdy <= 1'b0;
        end else if (ss.ack) begin
            o_pout_rdy <= 1'b1;
        end else if (i_pout_ack) begin
            o_pout_rdy <= 1'b0;
        end
    end

endmodule

/* hdl/pe.sv */
`timescale 1ns/1ps

module pe import pe_pkg::*; (
    input  logic             i_clk,
    input  logic             i_rst_n,
    // configuration
    input  logic [TAPWD-1:0] i_conf_ntap_m1,
    input  ps_mode_e         i_conf_ps_mode,
    // weight channel
    input  logic             i_weight_rdy,
    output logic             o_weight_ack,
    input  row_data_t        i_weight,
    // input channel
    input  logic             i_input_rdy,
    output logic             o_input_ack,
    input  data_t            i_input,
    // left neighbour psum
    input  logic             i_lpe_rdy,
    output logic             o_lpe_ack,
    input  row_psum_t        i_psum_lpe,
    // psum out
    output logic             o_pout_rdy,
    input  logic             i_pout_ack,
    output row_psum_t        o_psum
);

    pe_conf_t         conf;
    logic             wpad_write;
    logic [TAPWD-1:0] wpad_waddr;
    logic             wpad_read;
    logic [TAPWD-1:0] wpad_raddr;
    row_data_t        wpad_rdata;
    logic             ipad_write;
    logic [TAPWD-1:0] ipad_waddr;
    logic             ipad_read;
    logic [TAPWD-1:0] ipad_raddr;
    data_t            ipad_rdata;

    stage_if issue ();
    stage_if ss ();

    assign conf = '{ntap_m1: i_conf_ntap_m1, ps_mode: i_conf_ps_mode};

    // ========================================
    // scratchpads
    // ========================================

    rf_2p #(.LANES(1), .DEPTH(MAXTAP)) i_ipad (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_write (ipad_write),
        .i_waddr (ipad_waddr),
        .i_wdata (i_input),
        .i_read  (ipad_read),
        .i_raddr (ipad_raddr),
        .o_rdata (ipad_rdata)
    );

    rf_2p #(.LANES(PEROW), .DEPTH(MAXTAP)) i_wpad (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_write (wpad_write),
        .i_waddr (wpad_waddr),
        .i_wdata (i_weight),
        .i_read  (wpad_read),
        .i_raddr (wpad_raddr),
        .o_rdata (wpad_rdata)
    );

    // ========================================
    // control, MAC and psum out
    // ========================================

    datapath_controller i_dpc (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_conf       (conf),
        .i_weight_rdy (i_weight_rdy),
        .o_weight_ack (o_weight_ack),
        .i_input_rdy  (i_input_rdy),
        .o_input_ack  (o_input_ack),
        .o_wpad_write (wpad_write),
        .o_wpad_waddr (wpad_waddr),
        .o_ipad_write (ipad_write),
        .o_ipad_waddr (ipad_waddr),
        .issue        (issue.src)
    );

    mac_pipe i_mac_pipe (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .issue        (issue.dst),
        .ss           (ss.src),
        .o_ipad_read  (ipad_read),
        .o_ipad_raddr (ipad_raddr),
        .i_ipad_rdata (ipad_rdata),
        .o_wpad_read  (wpad_read),
        .o_wpad_raddr (wpad_raddr),
        .i_wpad_rdata (wpad_rdata)
    );

    psum_path i_psum_path (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .ss         (ss.dst),
        .i_lpe_rdy  (i_lpe_rdy),
        .o_lpe_ack  (o_lpe_ack),
        .i_psum_lpe (i_psum_lpe),
        .o_pout_rdy (o_pout_rdy),
        .i_pout_ack (i_pout_ack),
        .o_psum     (o_psum)
    );

endmodule

/* test/pe_asserts.sv */
`timescale 1ns/1ps

module pe_asserts import pe_pkg::*; (
    input logic      i_clk,
    input logic      i_rst_n,
    input logic      i_weight_rdy,
    input logic      i_weight_ack,
    input logic      i_input_rdy,
    input logic      i_input_ack,
    input logic      i_lpe_rdy,
    input logic      i_lpe_ack,
    input logic      i_pout_rdy,
    input logic      i_pout_ack,
    input row_psum_t i_psum
);

    // output held until taken
    a_pout_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pout_rdy && !i_pout_ack |=> i_pout_rdy && $stable(i_psum))
        else $error("o_pout_rdy or o_psum changed before i_pout_ack");

    // one pad load at a time
    a_load_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_weight_ack && i_input_ack))
        else $error("weight and input acks high together");

    a_weight_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_weight_ack |-> i_weight_rdy)
        else $error("o_weight_ack without i_weight_rdy");

    a_input_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_input_ack |-> i_input_rdy)
        else $error("o_input_ack without i_input_rdy");

    a_lpe_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_lpe_ack |-> i_lpe_rdy)
        else $error("o_lpe_ack without i_lpe_rdy");

    // quiet while in reset
    a_reset_quiet: assert property (@(posedge i_clk)
        !i_rst_n |-> !(i_weight_ack || i_input_ack || i_lpe_ack || i_pout_rdy))
        else $error("ack or o_pout_rdy high during reset");

endmodule

bind pe pe_asserts i_pe_asserts (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_weight_rdy (i_weight_rdy),
    .i_weight_ack (o_weight_ack),
    .i_input_rdy  (i_input_rdy),
    .i_input_ack  (o_input_ack),
    .i_lpe_rdy    (i_lpe_rdy),
    .i_lpe_ack    (o_lpe_ack),
    .i_pout_rdy   (o_pout_rdy),
    .i_pout_ack   (i_pout_ack),
    .i_psum       (o_psum)
);

/* test/pe_tb.sv */
`timescale 1ns/1ps

module pe_tb import pe_pkg::*; ();

    localparam int TIMEOUT = 500;

    typedef logic [PEROW*PSUMDWD-1:0] word_t;

    logic             i_clk;
    logic             i_rst_n;
    logic [TAPWD-1:0] i_conf_ntap_m1;
    ps_mode_e         i_conf_ps_mode;
    logic             i_weight_rdy;
    logic             o_weight_ack;
    row_data_t        i_weight;
    logic             i_input_rdy;
    logic             o_input_ack;
    data_t            i_input;
    logic             i_lpe_rdy;
    logic             o_lpe_ack;
    row_psum_t        i_psum_lpe;
    logic             o_pout_rdy;
    logic             i_pout_ack;
    row_psum_t        o_psum;

    integer    seed = 26968;
    row_data_t wmodel [MAXTAP];
    row_psum_t exp_q [$];
    logic      exp_acc_q [$];
    row_psum_t lpe_q [$];
    int        lpe_count = 0;
    int        acc_outs = 0;
    logic      bp_en = 1'b0;
    string     test_name = "reset";

    pe i_dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // ========================================
    // checking helpers
    // ========================================

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input word_t exp_v, input word_t act_v);
        if (exp_v !== act_v) begin
            fail_run($sformatf("error: %s: expected %h, actual %h", name, exp_v, act_v));
        end
    endtask

    task automatic check_outputs_idle(input string name);
        check_value({name, " weight ack"}, word_t'(0), word_t'(o_weight_ack));
        check_value({name, " input ack"}, word_t'(0), word_t'(o_input_ack));
        check_value({name, " lpe ack"}, word_t'(0), word_t'(o_lpe_ack));
        check_value({name, " pout rdy"}, word_t'(0), word_t'(o_pout_rdy));
    endtask

    function automatic logic ack_of(input int chan);
        case (chan)
            0: return o_weight_ack;
            1: return o_input_ack;
            default: return o_lpe_ack;
        endcase
    endfunction

    // entered just after driving on a falling edge
    // returns on the falling edge after the beat
    task automatic wait_ack(input int chan, input string what);
        int n;
        n = 0;
        #1;
        while (!ack_of(chan)) begin
            if (n >= TIMEOUT) begin
                fail_run($sformatf("timeout: %s channel was never acknowledged", what));
            end
            n++;
            @(negedge i_clk);
            #1;
        end
        @(negedge i_clk);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            if (n >= TIMEOUT) begin
                fail_run("timeout: o_pout_rdy never delivered the pending psum vectors");
            end
            n++;
            @(negedge i_clk);
        end
    endtask

    // ========================================
    // stimulus and reference model
    // ========================================

    task automatic load_weights(input int ntap);
        for (int t = 0; t < ntap; t++) begin
            wmodel[t] = row_data_t'($random(seed));
            i_weight = wmodel[t];
            i_weight_rdy = 1'b1;
            wait_ack(0, "weight");
        end
        i_weight_rdy = 1'b0;
    endtask

    task automatic send_window(input int ntap, input ps_mode_e mode);
        data_t     x [MAXTAP];
        row_psum_t lpe;
        row_psum_t expv;
        int        acc;
        for (int t = 0; t < ntap; t++) begin
            x[t] = data_t'($random(seed));
        end
        // signed row sums wrapped to the psum width
        for (int r = 0; r < PEROW; r++) begin
            lpe[r] = psum_t'($random(seed));
            acc = 0;
            for (int t = 0; t < ntap; t++) begin
                acc += int'(x[t]) * int'(wmodel[t][r]);
            end
            if (mode == PS_ACC_LPE) begin
                acc += int'(lpe[r]);
            end
            expv[r] = psum_t'(acc);
        end
        exp_q.push_back(expv);
        exp_acc_q.push_back(mode == PS_ACC_LPE);
        if (mode == PS_ACC_LPE) begin
            lpe_q.push_back(lpe);
        end
        for (int t = 0; t < ntap; t++) begin
            i_input = x[t];
            i_input_rdy = 1'b1;
            wait_ack(1, "input");
        end
    endtask

    // left neighbour psum after a random gap
    initial begin : lpe_driver
        int gap;
        i_lpe_rdy = 1'b0;
        i_psum_lpe = '0;
        forever begin
            @(negedge i_clk);
            if (lpe_q.size() > 0) begin
                gap = $random(seed) & 7;
                repeat (gap) @(negedge i_clk);
                i_psum_lpe = lpe_q[0];
                i_lpe_rdy = 1'b1;
                wait_ack(2, "left psum");
                void'(lpe_q.pop_front());
                lpe_count++;
                i_lpe_rdy = 1'b0;
            end
        end
    end

    // output consumer with random stall stretches
    initial begin : consumer
        int        stall;
        row_psum_t expv;
        logic      is_acc;
        stall = 0;
        i_pout_ack = 1'b0;
        forever begin
            @(negedge i_clk);
            if (bp_en && stall == 0 && ($random(seed) & 3) == 0) begin
                stall = 1 + ($random(seed) & 15);
            end
            if (stall > 0) begin
                stall--;
                i_pout_ack = 1'b0;
            end else begin
                i_pout_ack = o_pout_rdy && i_rst_n;
            end
            #1;
            if (i_pout_ack) begin
                if (exp_q.size() == 0) begin
                    fail_run("o_pout_rdy offered a psum vector with no window pending");
                end
                expv = exp_q.pop_front();
                is_acc = exp_acc_q.pop_front();
                if (is_acc && lpe_count <= acc_outs) begin
                    fail_run("accumulated psum appeared before its left psum transfer");
                end
                if (is_acc) begin
                    acc_outs++;
                end
                check_value({test_name, " psum"}, word_t'(expv), word_t'(o_psum));
            end
        end
    end

    // ========================================
    // test sequence
    // ========================================

    initial begin : main
        int ntap;
        int nwin;
        i_rst_n = 1'b0;
        i_conf_ntap_m1 = '0;
        i_conf_ps_mode = PS_LOCAL;
        i_weight_rdy = 1'b0;
        i_weight = '0;
        i_input_rdy = 1'b0;
        i_input = '0;
        repeat (4) begin
            @(negedge i_clk);
            check_outputs_idle("in reset");
        end
        i_rst_n = 1'b1;
        @(negedge i_clk);
        check_outputs_idle("after reset");

        // a random ntap first and then every count from 1 to 8
        for (int p = 0; p < 9; p++) begin
            if (p == 0) begin
                ntap = 1 + ($random(seed) & 7);
            end else begin
                ntap = ((p * 5 + 3) % 8) + 1;
            end
            i_conf_ntap_m1 = TAPWD'(ntap - 1);
            i_conf_ps_mode = ((p & 1) != 0) ? PS_ACC_LPE : PS_LOCAL;
            bp_en = ((p & 2) != 0);
            test_name = $sformatf("phase %0d ntap %0d", p, ntap);
            load_weights(ntap);
            nwin = 3 + ($random(seed) & 3);
            for (int w = 0; w < nwin; w++) begin
                send_window(ntap, i_conf_ps_mode);
            end
            i_input_rdy = 1'b0;
            wait_drain();
        end

        repeat (4) @(negedge i_clk);
        check_value("stray output", word_t'(0), word_t'(o_pout_rdy));
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* tb.f */
common/pe_pkg.sv
common/stage_if.sv
hdl/rf_2p.sv
pe_core/datapath_controller.sv
pe_core/mac_pipe.sv
hdl/psum_path.sv
hdl/pe.sv
test/pe_asserts.sv
test/pe_tb.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module pe_tb -f tb.f -Mdir obj_dir -o pe_tb

run: compile
	./obj_dir/pe_tb | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
